// File: project.f
src/aesFieldPkg.sv
src/aesBlockPkg.sv
src/aesKeyScheduleStep.sv
src/aesRoundDatapath.sv
src/aesInputStage.sv
src/aesRoundEngine.sv
src/aesEncryptTop.sv
tests/tbClock.sv
tests/aesEncryptTb_asserts.sv
tests/aesEncryptTb.sv

// File: tests/aesEncryptTb.sv
module aesEncryptTb;

    // Four known vectors and 40 random blocks at about 25 cycles each
    localparam int maxCycles = 2000;
    localparam int numRandom = 40;

    localparam aesBlockPkg::blockWord keyC1 = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aesBlockPkg::blockWord ptC1  = 128'h00112233445566778899aabbccddeeff;
    localparam aesBlockPkg::blockWord keyB  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aesBlockPkg::blockWord ptB   = 128'h3243f6a8885a308d313198a2e0370734;

    logic                  clk;
    logic                  rstN;
    logic                  inValid;
    logic                  inReady;
    aesBlockPkg::blockWord plainText;
    aesBlockPkg::blockWord cipherKey;
    logic                  outValid;
    logic                  outReady;
    aesBlockPkg::blockWord cipherText;
    logic                  randomReady = 1'b0;
    int                    inCount = 0;
    int                    outCount = 0;
    int                    cycleCount = 0;

    tbClock tbClock_i (
        .clk (clk)
    );

    aesEncryptTop aesEncryptTop_i (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inReady    (inReady),
        .plainText  (plainText),
        .cipherKey  (cipherKey),
        .outValid   (outValid),
        .outReady   (outReady),
        .cipherText (cipherText)
    );

    function automatic aesBlockPkg::blockWord randomWord();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic sendBlock(input aesBlockPkg::blockWord pt,
                             input aesBlockPkg::blockWord key);
        plainText = pt;
        cipherKey = key;
        inValid   = 1'b1;
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
        inCount++;
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic waitDrained();
        while (outCount != inCount) begin
            @(negedge clk);
        end
    endtask

    // Full speed sink, or random back-pressure
    task automatic driveReady();
        forever begin
            @(negedge clk);
            if (randomReady) begin
                outReady = 1'($urandom_range(0, 1));
            end else begin
                outReady = 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rstN && outValid && outReady) begin
            outCount <= outCount + 1;
        end
    end

    // ------------------------------------------------------------
    // Failure poll and timeout
    // ------------------------------------------------------------

    initial begin
        while (aesEncryptTop_i.aesEncryptTbAsserts_i.failCount == 0
               && cycleCount < maxCycles) begin
            @(negedge clk);
            cycleCount++;
        end
        if (aesEncryptTop_i.aesEncryptTbAsserts_i.failCount != 0) begin
            $display("Test failed");
            $fatal(1, "Assertion failure, run stopped");
        end else begin
            $display("Run timed out after %0d cycles", cycleCount);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin
        void'($urandom(19));
        rstN      = 1'b0;
        inValid   = 1'b0;
        plainText = '0;
        cipherKey = '0;
        outReady  = 1'b0;
        fork
            driveReady();
        join_none

        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // Known vectors through an empty pipeline
        sendBlock(ptC1, keyC1);
        waitDrained();
        sendBlock(ptB, keyB);
        waitDrained();

        // Random traffic, known vectors mixed in
        randomReady = 1'b1;
        for (int i = 0; i < numRandom; i++) begin
            repeat ($urandom_range(0, 2)) @(negedge clk);
            if (i == 12) begin
                sendBlock(ptC1, keyC1);
            end else if (i == 27) begin
                sendBlock(ptB, keyB);
            end
            sendBlock(randomWord(), randomWord());
        end
        waitDrained();
        repeat (2) @(negedge clk);

        if (aesEncryptTop_i.aesEncryptTbAsserts_i.failCount == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Assertion failure at end of run");
        end
    end

endmodule

// File: tests/aesEncryptTb_asserts.sv
module aesEncryptTbAsserts (
    input logic                  clk,
    input logic                  rstN,
    input logic                  inValid,
    input logic                  inReady,
    input aesBlockPkg::blockWord plainText,
    input aesBlockPkg::blockWord cipherKey,
    input logic                  outValid,
    input logic                  outReady,
    input aesBlockPkg::blockWord cipherText,
    input logic                  stageValid,
    input logic                  stageReady
);

    localparam int latency = aesBlockPkg::numRounds;

    // FIPS-197 C.1
    localparam aesBlockPkg::blockWord keyC1 = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aesBlockPkg::blockWord ptC1  = 128'h00112233445566778899aabbccddeeff;
    localparam aesBlockPkg::blockWord ctC1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    // FIPS-197 Appendix B
    localparam aesBlockPkg::blockWord keyB  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aesBlockPkg::blockWord ptB   = 128'h3243f6a8885a308d313198a2e0370734;
    localparam aesBlockPkg::blockWord ctB   = 128'h3925841d02dc09fbdc118597196a0b32;

    int failCount = 0;

    logic                  inXfer;
    logic                  outXfer;
    logic                  knownQ [4];
    aesBlockPkg::blockWord expectQ [4];
    logic [1:0]            wrPtr;
    logic [1:0]            rdPtr;
    int                    inFlight;
    aesBlockPkg::blockWord prevText;
    logic                  frontKnown;
    aesBlockPkg::blockWord frontExpect;

    function automatic logic isKnownVector(input aesBlockPkg::blockWord key,
                                           input aesBlockPkg::blockWord pt);
        return (key == keyC1 && pt == ptC1) || (key == keyB && pt == ptB);
    endfunction

    function automatic aesBlockPkg::blockWord knownCipher(input aesBlockPkg::blockWord key,
                                                          input aesBlockPkg::blockWord pt);
        if (key == keyC1 && pt == ptC1) begin
            return ctC1;
        end
        return ctB;
    endfunction

    assign inXfer      = inValid && inReady;
    assign outXfer     = outValid && outReady;
    assign frontKnown  = knownQ[rdPtr];
    assign frontExpect = expectQ[rdPtr];

    // ------------------------------------------------------------
    // Blocks in flight, oldest first
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        prevText <= cipherText;
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            inFlight <= 0;
        end else begin
            if (inXfer) begin
                knownQ[wrPtr]  <= isKnownVector(cipherKey, plainText);
                expectQ[wrPtr] <= knownCipher(cipherKey, plainText);
                wrPtr          <= wrPtr + 2'd1;
            end
            if (outXfer) begin
                rdPtr <= rdPtr + 2'd1;
            end
            inFlight <= inFlight + (inXfer ? 1 : 0) - (outXfer ? 1 : 0);
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    resetState: assert property (@(posedge clk) $rose(rstN) |-> !outValid && inReady)
        else begin
            $error("error at %0t: outValid expected 0 actual %b, inReady expected 1 actual %b",
                   $time, $sampled(outValid), $sampled(inReady));
            failCount++;
        end

    // Empty pipeline, input transfer to outValid
    topLatency: assert property (@(posedge clk) disable iff (!rstN)
        inXfer && inFlight == 0 |=> !outValid [*latency+1] ##1 outValid)
        else begin
            $error("outValid did not rise 11 cycles after the input transfer");
            failCount++;
        end

    engineLatency: assert property (@(posedge clk) disable iff (!rstN)
        stageValid && stageReady |=> !outValid [*latency] ##1 outValid)
        else begin
            $error("outValid did not rise 10 cycles after the engine took a block");
            failCount++;
        end

    holdValid: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid)
        else begin
            $error("outValid dropped before the result was taken");
            failCount++;
        end

    holdText: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> cipherText == prevText)
        else begin
            $error("error at %0t: cipherText expected %h actual %h",
                   $time, $sampled(prevText), $sampled(cipherText));
            failCount++;
        end

    noExtraOutput: assert property (@(posedge clk) disable iff (!rstN)
        outXfer |-> inFlight > 0)
        else begin
            $error("An output transfer came without a block in flight");
            failCount++;
        end

    inFlightLimit: assert property (@(posedge clk) disable iff (!rstN) inFlight <= 2)
        else begin
            $error("More than two blocks are in flight");
            failCount++;
        end

    knownResult: assert property (@(posedge clk) disable iff (!rstN)
        outXfer && frontKnown |-> cipherText == frontExpect)
        else begin
            $error("error at %0t: cipherText expected %h actual %h",
                   $time, $sampled(frontExpect), $sampled(cipherText));
            failCount++;
        end

endmodule

bind aesEncryptTop aesEncryptTbAsserts aesEncryptTbAsserts_i (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (inValid),
    .inReady    (inReady),
    .plainText  (plainText),
    .cipherKey  (cipherKey),
    .outValid   (outValid),
    .outReady   (outReady),
    .cipherText (cipherText),
    .stageValid (stageValid),
    .stageReady (stageReady)
);

// File: tests/tbClock.sv
module tbClock (
    output logic clk
);

    // 40 units per period
    localparam int halfPeriod = 20;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

endmodule

// File: src/aesEncryptTop.sv
module aesEncryptTop (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  aesBlockPkg::blockWord plainText,
    input  aesBlockPkg::blockWord cipherKey,
    output logic                  outValid,
    input  logic                  outReady,
    output aesBlockPkg::blockWord cipherText
);

    // Input stage to round engine
    logic                  stageValid;
    logic                  stageReady;
    aesBlockPkg::blockWord stageState;
    aesBlockPkg::blockWord stageKey;

    // Whitening and one-block buffer
    aesInputStage aesInputStage_i (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inReady    (inReady),
        .plainText  (plainText),
        .cipherKey  (cipherKey),
        .stageValid (stageValid),
        .stageReady (stageReady),
        .stageState (stageState),
        .stageKey   (stageKey)
    );

    // Ten rounds and the result hold
    aesRoundEngine aesRoundEngine_i (
        .clk        (clk),
        .rstN       (rstN),
        .stageValid (stageValid),
        .stageReady (stageReady),
        .stageState (stageState),
        .stageKey   (stageKey),
        .outValid   (outValid),
        .outReady   (outReady),
        .cipherText (cipherText)
    );

endmodule

// File: src/aesRoundEngine.sv
module aesRoundEngine (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stageValid,
    output logic                  stageReady,
    input  aesBlockPkg::blockWord stageState,
    input  aesBlockPkg::blockWord stageKey,
    output logic                  outValid,
    input  logic                  outReady,
    output aesBlockPkg::blockWord cipherText
);

    localparam aesBlockPkg::roundIndex lastRound =
        aesBlockPkg::roundIndex'(aesBlockPkg::numRounds);

    logic                  busy;
    logic                  holdValid;
    aesBlockPkg::roundIndex roundReg;
    aesBlockPkg::blockWord stateReg;
    aesBlockPkg::blockWord keyReg;
    aesBlockPkg::blockWord nextKey;
    aesBlockPkg::blockWord nextState;
    logic                  finalRound;
    logic                  accept;
    logic                  resultTaken;

    // ------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------

    assign resultTaken = holdValid && outReady;

    // Idle, or the held result goes out on this edge
    assign stageReady = (!busy && !holdValid) || resultTaken;
    assign accept     = stageValid && stageReady;

    // ------------------------------------------------------------
    // One round per cycle
    // ------------------------------------------------------------

    assign finalRound = (roundReg == lastRound);

    aesKeyScheduleStep aesKeyScheduleStep_i (
        .key     (keyReg),
        .round   (roundReg),
        .nextKey (nextKey)
    );

    aesRoundDatapath aesRoundDatapath_i (
        .state      (stateReg),
        .roundKey   (nextKey),
        .finalRound (finalRound),
        .nextState  (nextState)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy      <= 1'b0;
            holdValid <= 1'b0;
            roundReg  <= '0;
        end else begin
            if (accept) begin
                busy     <= 1'b1;
                roundReg <= 4'd1;
            end else if (busy) begin
                roundReg <= roundReg + 4'd1;
                if (finalRound) begin
                    busy <= 1'b0;
                end
            end

            // busy and holdValid never overlap
            if (busy && finalRound) begin
                holdValid <= 1'b1;
            end else if (resultTaken) begin
                holdValid <= 1'b0;
            end
        end
    end

    // State stays put while the result is held
    always_ff @(posedge clk) begin
        if (accept) begin
            stateReg <= stageState;
            keyReg   <= stageKey;
        end else if (busy) begin
            stateReg <= nextState;
            keyReg   <= nextKey;
        end
    end

    assign outValid   = holdValid;
    assign cipherText = stateReg;

endmodule

// File: src/aesInputStage.sv
module aesInputStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  aesBlockPkg::blockWord plainText,
    input  aesBlockPkg::blockWord cipherKey,
    output logic                  stageValid,
    input  logic                  stageReady,
    output aesBlockPkg::blockWord stageState,
    output aesBlockPkg::blockWord stageKey
);

    logic                  full;
    aesBlockPkg::blockWord stateReg;
    aesBlockPkg::blockWord keyReg;
    logic                  accept;

    // Free slot, or the held block leaves this cycle
    assign inReady = !full || stageReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (stageReady) begin
            full <= 1'b0;
        end
    end

    // Initial AddRoundKey with the cipher key itself
    always_ff @(posedge clk) begin
        if (accept) begin
            stateReg <= plainText ^ cipherKey;
            keyReg   <= cipherKey;
        end
    end

    assign stageValid = full;
    assign stageState = stateReg;
    assign stageKey   = keyReg;

endmodule

// File: src/aesRoundDatapath.sv
module aesRoundDatapath (
    input  aesBlockPkg::blockWord state,
    input  aesBlockPkg::blockWord roundKey,
    input  logic                  finalRound,
    output aesBlockPkg::blockWord nextState
);

    aesBlockPkg::stateWord inView;
    aesBlockPkg::stateWord subView;
    aesBlockPkg::stateWord shiftView;
    aesBlockPkg::stateWord mixView;

    assign inView = state;

    // ------------------------------------------------------------
    // SubBytes and ShiftRows on the byte view
    // ------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            subView.bytes[i] = aesFieldPkg::subByte(inView.bytes[i]);
        end
        // Row r rotates left by r columns
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shiftView.bytes[4*c + r] = subView.bytes[4*((c + r) % 4) + r];
            end
        end
    end

    // ------------------------------------------------------------
    // MixColumns on the column view
    // ------------------------------------------------------------

    always_comb begin
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        for (int c = 0; c < 4; c++) begin
            a0 = shiftView.cols[c][31:24];
            a1 = shiftView.cols[c][23:16];
            a2 = shiftView.cols[c][15:8];
            a3 = shiftView.cols[c][7:0];
            // Rows of the circulant 02 03 01 01; 3x is 2x ^ x
            mixView.cols[c][31:24] = aesFieldPkg::xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3;
            mixView.cols[c][23:16] = aesFieldPkg::xtime(a1 ^ a2) ^ a2 ^ a3 ^ a0;
            mixView.cols[c][15:8]  = aesFieldPkg::xtime(a2 ^ a3) ^ a3 ^ a0 ^ a1;
            mixView.cols[c][7:0]   = aesFieldPkg::xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2;
        end
    end

    // Last round has no column mix
    assign nextState = (finalRound ? shiftView : mixView) ^ roundKey;

endmodule

// File: src/aesKeyScheduleStep.sv
module aesKeyScheduleStep (
    input  aesBlockPkg::blockWord  key,
    input  aesBlockPkg::roundIndex round,
    output aesBlockPkg::blockWord  nextKey
);

    aesBlockPkg::stateWord keyView;
    aesBlockPkg::stateWord nextView;
    logic [31:0] rotWord;
    logic [31:0] subWord;
    logic [31:0] mixWord;

    assign keyView = key;

    // RotWord on the last column
    assign rotWord = {keyView.cols[3][23:0], keyView.cols[3][31:24]};

    always_comb begin
        // SubWord, one S-box per byte
        for (int i = 0; i < 4; i++) begin
            subWord[8*i +: 8] = aesFieldPkg::subByte(rotWord[8*i +: 8]);
        end
        mixWord = subWord ^ {aesFieldPkg::roundConstant(round), 24'h000000};

        // Each new word feeds the next one
        nextView.cols[0] = keyView.cols[0] ^ mixWord;
        nextView.cols[1] = keyView.cols[1] ^ nextView.cols[0];
        nextView.cols[2] = keyView.cols[2] ^ nextView.cols[1];
        nextView.cols[3] = keyView.cols[3] ^ nextView.cols[2];
    end

    assign nextKey = nextView;

endmodule

// File: src/aesBlockPkg.sv
package aesBlockPkg;

    // ------------------------------------------------------------
    // AES-128 block geometry
    // ------------------------------------------------------------

    localparam int blockWidth = 128;

    // Rounds after the initial whitening
    localparam int numRounds = 10;

    // Plain bus for blocks and keys
    typedef logic [blockWidth-1:0] blockWord;

    // Round counter, 1 to numRounds while running
    typedef logic [3:0] roundIndex;

    // ------------------------------------------------------------
    // State views
    // ------------------------------------------------------------

    // Byte 0 and column 0 sit at the top of the word.
    // Byte 4*c + r is row r of column c
    typedef union packed {
        logic [0:15][7:0] bytes;
        logic [0:3][31:0] cols;
    } stateWord;

endpackage

// File: src/aesFieldPkg.sv
package aesFieldPkg;

    // ------------------------------------------------------------
    // GF(2^8) arithmetic over x^8 + x^4 + x^3 + x + 1
    // ------------------------------------------------------------

    // Folded back in when a doubling overflows bit 7
    localparam logic [7:0] reductionPoly = 8'h1B;

    // Multiply by 2
    function automatic logic [7:0] xtime(input logic [7:0] b);
        if (b[7]) begin
            return {b[6:0], 1'b0} ^ reductionPoly;
        end
        return {b[6:0], 1'b0};
    endfunction

    // Shift-and-add product of two field elements
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] term;
        acc  = 8'h00;
        term = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ term;
            end
            term = xtime(term);
        end
        return acc;
    endfunction

    // Inverse as a^254; zero maps to zero on its own
    function automatic logic [7:0] gfInverse(input logic [7:0] a);
        logic [7:0] square;
        logic [7:0] result;
        square = a;
        result = 8'h01;
        // Accumulate a^2 * a^4 * ... * a^128
        for (int i = 1; i < 8; i++) begin
            square = gfMul(square, square);
            result = gfMul(result, square);
        end
        return result;
    endfunction

    // ------------------------------------------------------------
    // S-box and round constants
    // ------------------------------------------------------------

    // Forward S-box, inverse followed by the affine map
    function automatic logic [7:0] subByte(input logic [7:0] b);
        logic [7:0] inv;
        inv = gfInverse(b);
        return inv
            ^ {inv[6:0], inv[7]}
            ^ {inv[5:0], inv[7:6]}
            ^ {inv[4:0], inv[7:5]}
            ^ {inv[3:0], inv[7:4]}
            ^ 8'h63;
    endfunction

    // Rcon for rounds 1 to 10 is 2^(round-1)
    function automatic logic [7:0] roundConstant(input logic [3:0] round);
        logic [7:0] rc;
        rc = 8'h01;
        for (int i = 2; i <= 10; i++) begin
            if (i <= round) begin
                rc = xtime(rc);
            end
        end
        return rc;
    endfunction

endpackage
